// ==== include/sdram_config.svh ====
// SDRAM controller configuration: device geometry, CPU address map and timing counts
`ifndef SDRAM_CONFIG_SVH
`define SDRAM_CONFIG_SVH

// device geometry, 32M x16 part
`define ROW_BITS            13
`define COL_BITS            10
`define BANK_BITS           2
`define DATA_BITS           16

// where the fields sit in the 68000 byte address
`define BANK_MSB            25
`define BANK_LSB            24
`define ROW_MSB             23
`define ROW_LSB             11
`define COL_MSB             10
`define COL_LSB             1            // A0 is the byte lane, not used for words

// timing counts in controller clocks
`define POWER_UP_CYCLES     8            // short power-up wait for simulation
`define INIT_REFRESHES      2            // auto-refreshes during init
`define REFRESH_GAP_CYCLES  3            // NOPs after each auto-refresh
`define MRS_GAP_CYCLES      2            // NOPs after load mode
`define REFRESH_INTERVAL    375          // 7.5 us at 50 MHz
`define CAS_LATENCY         2

// fixed address bus words
`define MODE_WORD           13'h220      // CL2, burst of 1, single write
`define A10_PRECHARGE       13'h400      // A10 high: all banks or auto-precharge

// wait and interval counter width
`define TIMER_BITS          16

`endif

// ==== source/sdramPkg.sv ====
// SDRAM controller types: command word views, address source and sequencer states
package sdramPkg;

    // device opcodes as {CKE, CS_L, RAS_L, CAS_L, WE_L}
    typedef enum logic [4:0] {
        powerUp     = 5'b00000,          // CKE and CS low while power settles
        deselect    = 5'b11111,
        nop         = 5'b10111,
        activate    = 5'b10011,          // opens a row, row on the address bus
        read        = 5'b10101,          // A10 high gives auto-precharge
        write       = 5'b10100,          // A10 high gives auto-precharge
        precharge   = 5'b10010,          // A10 high closes all banks
        autoRefresh = 5'b10001,
        loadMode    = 5'b10000           // mode word on the address bus
    } sdramOpE;

    // same five bits seen as the pins, msb first
    typedef struct packed {
        logic cke;
        logic csL;
        logic rasL;
        logic casL;
        logic weL;
    } sdramPinsS;

    // the sequencer names the opcode, the driver unpacks the pins
    typedef union packed {
        sdramOpE   op;
        sdramPinsS pins;
    } sdramCmdU;

    // source of the registered SDRAM address
    typedef enum logic [2:0] {
        none,
        row,
        column,
        prechargeAll,
        modeWord
    } addrSelE;

    // sequencer FSM states
    typedef enum logic [4:0] {
        stPowerUp, stInitNop, stInitPrecharge, stInitRefresh, stInitGap,
        stLoadMode, stModeGap, stIdle,
        stRefPrecharge, stRefNop, stRefRefresh, stRefGap,
        stActivate, stReadCmd, stCasWait,
        stWriteWait, stWriteCmd, stWriteRecover, stTerminate
    } seqStateE;

endpackage

// ==== source/dramSequencer.sv ====
// DRAM sequencer: init, refresh, read and write FSM with the 68000 bus handshake
`timescale 1ns/1ps

`include "sdram_config.svh"

module dramSequencer
    import sdramPkg::*;
(
    input  logic     Clock,
    input  logic     Reset_L,
    input  logic     DramSelect_L,         // address decoder hit
    input  logic     AS_L,
    input  logic     WE_L,
    input  logic     UDS_L,
    input  logic     LDS_L,
    input  logic     RefreshDue,
    output sdramCmdU Cmd,                  // opcode for the next edge
    output addrSelE  AddrSel,              // address source for the next edge
    output logic     RefreshAck,
    output logic     WriteDrive,
    output logic     CaptureRead,
    output logic     Dtack_L,
    output logic     ResetOut_L
);

    seqStateE               state;
    seqStateE               nextState;
    logic [`TIMER_BITS-1:0] waitCnt;
    logic [`TIMER_BITS-1:0] waitLoadValue;
    logic                   waitLoad;
    logic                   waitDone;
    logic [3:0]             initRefCnt;      // auto-refreshes issued during init
    logic                   isWrite;         // direction of the current access
    logic                   cpuRequest;
    logic                   strobeActive;

    assign cpuRequest   = !DramSelect_L && !AS_L;
    assign strobeActive = !UDS_L || !LDS_L;        // either byte lane
    assign waitDone     = (waitCnt == '0);

    //////////////////////////////////////////////////////////////////////
    // wait counter, loads then counts down and parks at zero
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge Clock or negedge Reset_L) begin
        if (!Reset_L) begin
            waitCnt <= `TIMER_BITS'(`POWER_UP_CYCLES - 1);   // power-up wait starts at reset
        end else if (waitLoad) begin
            waitCnt <= waitLoadValue;
        end else if (!waitDone) begin
            waitCnt <= waitCnt - 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // state and bus-side registers
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge Clock or negedge Reset_L) begin
        if (!Reset_L) begin
            state      <= stPowerUp;
            initRefCnt <= '0;
            isWrite    <= 1'b0;
            Dtack_L    <= 1'b1;
            ResetOut_L <= 1'b0;              // CPU held in reset through init
        end else begin
            state <= nextState;
            if (state == stInitRefresh) begin
                initRefCnt <= initRefCnt + 1'b1;
            end
            if (state == stIdle && cpuRequest) begin
                isWrite <= !WE_L;            // latched with the request
            end
            Dtack_L <= (nextState != stTerminate);   // low for the whole terminate state
            if (nextState == stIdle) begin
                ResetOut_L <= 1'b1;          // first idle ends init
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // next state and command decode
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        nextState     = state;
        Cmd.op        = nop;
        AddrSel       = none;
        waitLoad      = 1'b0;
        waitLoadValue = '0;
        RefreshAck    = 1'b0;
        WriteDrive    = 1'b0;
        CaptureRead   = 1'b0;
        case (state)
            stPowerUp: begin
                Cmd.op = powerUp;
                if (waitDone) nextState = stInitNop;
            end
            stInitNop:       nextState = stInitPrecharge;
            stInitPrecharge: begin
                Cmd.op    = precharge;
                AddrSel   = prechargeAll;
                nextState = stInitRefresh;
            end
            stInitRefresh: begin
                Cmd.op        = autoRefresh;
                waitLoad      = 1'b1;
                waitLoadValue = `TIMER_BITS'(`REFRESH_GAP_CYCLES - 1);
                nextState     = stInitGap;
            end
            stInitGap: begin
                if (waitDone) begin
                    // count includes the refresh just issued
                    nextState = (initRefCnt == 4'(`INIT_REFRESHES)) ? stLoadMode
                                                                     : stInitRefresh;
                end
            end
            stLoadMode: begin
                Cmd.op        = loadMode;
                AddrSel       = modeWord;
                waitLoad      = 1'b1;
                waitLoadValue = `TIMER_BITS'(`MRS_GAP_CYCLES - 1);
                nextState     = stModeGap;
            end
            stModeGap: if (waitDone) nextState = stIdle;
            stIdle: begin
                if (cpuRequest) begin
                    nextState = stActivate;          // CPU wins over a due refresh
                end else if (RefreshDue) begin
                    RefreshAck = 1'b1;
                    nextState  = stRefPrecharge;
                end
            end
            stRefPrecharge: begin
                Cmd.op    = precharge;
                AddrSel   = prechargeAll;
                nextState = stRefNop;
            end
            stRefNop:       nextState = stRefRefresh;
            stRefRefresh: begin
                Cmd.op        = autoRefresh;
                waitLoad      = 1'b1;
                waitLoadValue = `TIMER_BITS'(`REFRESH_GAP_CYCLES - 1);
                nextState     = stRefGap;
            end
            stRefGap: if (waitDone) nextState = stIdle;
            stActivate: begin
                Cmd.op    = activate;
                AddrSel   = row;
                nextState = isWrite ? stWriteWait : stReadCmd;
            end
            stReadCmd: begin
                Cmd.op        = read;
                AddrSel       = column;
                waitLoad      = 1'b1;
                waitLoadValue = `TIMER_BITS'(`CAS_LATENCY - 1);
                nextState     = stCasWait;
            end
            stCasWait: begin
                if (waitDone) begin
                    CaptureRead = 1'b1;      // data lands with Dtack_L
                    nextState   = stTerminate;
                end
            end
            stWriteWait: if (strobeActive) nextState = stWriteCmd;   // data valid with DS
            stWriteCmd: begin
                Cmd.op     = write;
                AddrSel    = column;
                WriteDrive = 1'b1;
                nextState  = stWriteRecover;
            end
            stWriteRecover: nextState = stTerminate;
            stTerminate:    if (!strobeActive) nextState = stIdle;   // CPU ended its cycle
            default:        nextState = stPowerUp;
        endcase
    end

endmodule

// ==== source/refreshScheduler.sv ====
// Refresh scheduler: interval counter that raises a sticky refresh request
`timescale 1ns/1ps

`include "sdram_config.svh"

module refreshScheduler (
    input  logic Clock,
    input  logic Reset_L,
    input  logic RefreshAck,           // sequencer has started a refresh
    output logic RefreshDue
);

    logic [`TIMER_BITS-1:0] intervalCnt;

    //////////////////////////////////////////////////////////////////////
    // interval countdown, reloaded by each ack
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge Clock or negedge Reset_L) begin
        if (!Reset_L) begin
            intervalCnt <= `TIMER_BITS'(`REFRESH_INTERVAL);
            RefreshDue  <= 1'b0;
        end else if (RefreshAck) begin
            intervalCnt <= `TIMER_BITS'(`REFRESH_INTERVAL);
            RefreshDue  <= 1'b0;
        end else if (intervalCnt != '0) begin
            intervalCnt <= intervalCnt - 1'b1;
        end else begin
            RefreshDue <= 1'b1;            // stays up through a stalled CPU cycle
        end
    end

endmodule

// ==== source/sdramCommandDriver.sv ====
// SDRAM command driver: registers the command pins, device address and bank
`timescale 1ns/1ps

`include "sdram_config.svh"

module sdramCommandDriver
    import sdramPkg::*;
(
    input  logic                  Clock,
    input  logic                  Reset_L,
    input  sdramCmdU              Cmd,
    input  addrSelE               AddrSel,
    input  logic [31:0]           Address,        // 68000 byte address
    output logic                  SDram_CKE_H,
    output logic                  SDram_CS_L,
    output logic                  SDram_RAS_L,
    output logic                  SDram_CAS_L,
    output logic                  SDram_WE_L,
    output logic [`ROW_BITS-1:0]  SDram_Addr,
    output logic [`BANK_BITS-1:0] SDram_BA
);

    logic [`ROW_BITS-1:0] addrNext;

    //////////////////////////////////////////////////////////////////////
    // address source mux
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        case (AddrSel)
            row:          addrNext = Address[`ROW_MSB:`ROW_LSB];
            column:       addrNext = `A10_PRECHARGE |
                                     `ROW_BITS'(Address[`COL_MSB:`COL_LSB]);   // auto-precharge
            prechargeAll: addrNext = `A10_PRECHARGE;
            modeWord:     addrNext = `MODE_WORD;
            default:      addrNext = '0;
        endcase
    end

    // pins come from the pin view of the command word
    always_ff @(posedge Clock or negedge Reset_L) begin
        if (!Reset_L) begin
            SDram_CKE_H <= 1'b0;           // powerUp code, all low
            SDram_CS_L  <= 1'b0;
            SDram_RAS_L <= 1'b0;
            SDram_CAS_L <= 1'b0;
            SDram_WE_L  <= 1'b0;
        end else begin
            SDram_CKE_H <= Cmd.pins.cke;
            SDram_CS_L  <= Cmd.pins.csL;
            SDram_RAS_L <= Cmd.pins.rasL;
            SDram_CAS_L <= Cmd.pins.casL;
            SDram_WE_L  <= Cmd.pins.weL;
        end
    end

    // address and bank move with the pins
    always_ff @(posedge Clock) begin
        SDram_Addr <= addrNext;
        SDram_BA   <= Address[`BANK_MSB:`BANK_LSB];   // don't care outside an access
    end

endmodule

// ==== source/dramDataPath.sv ====
// DRAM data path: write data drive to the DQ pins and read data capture for the CPU
`timescale 1ns/1ps

`include "sdram_config.svh"

module dramDataPath (
    input  logic                  Clock,
    input  logic                  Reset_L,
    input  logic                  WriteDrive,      // high in the write command cycle
    input  logic                  CaptureRead,     // one cycle, CAS latency met
    input  logic [`DATA_BITS-1:0] DataIn,          // from the 68000
    input  logic [`DATA_BITS-1:0] DqIn,            // from the SDRAM
    output logic [`DATA_BITS-1:0] DqOut,
    output logic                  DqOutEnable,     // board-level tristate control
    output logic [`DATA_BITS-1:0] DataOut
);

    //////////////////////////////////////////////////////////////////////
    // write side, aligned with the write command pins
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge Clock or negedge Reset_L) begin
        if (!Reset_L) begin
            DqOutEnable <= 1'b0;           // bus released during init
        end else begin
            DqOutEnable <= WriteDrive;
        end
    end

    always_ff @(posedge Clock) begin
        if (WriteDrive) begin
            DqOut <= DataIn;               // full word, both lanes
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read side, held for the CPU until the next read
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge Clock or negedge Reset_L) begin
        if (!Reset_L) begin
            DataOut <= '0;
        end else if (CaptureRead) begin
            DataOut <= DqIn;
        end
    end

endmodule

// ==== source/m68kDramController.sv ====
// 68000 SDRAM controller top: sequencer, refresh scheduler, command driver and data path
`timescale 1ns/1ps

module m68kDramController
    import sdramPkg::*;
(
    input  logic        Clock,
    input  logic        Reset_L,
    input  logic [31:0] Address,       // CPU side
    input  logic [15:0] DataIn,
    input  logic        UDS_L,
    input  logic        LDS_L,
    input  logic        DramSelect_L,
    input  logic        WE_L,
    input  logic        AS_L,
    input  logic [15:0] DqIn,          // SDRAM side
    output logic [15:0] DataOut,
    output logic        SDram_CKE_H,
    output logic        SDram_CS_L,
    output logic        SDram_RAS_L,
    output logic        SDram_CAS_L,
    output logic        SDram_WE_L,
    output logic [12:0] SDram_Addr,
    output logic [1:0]  SDram_BA,
    output logic [15:0] DqOut,
    output logic        DqOutEnable,
    output logic        Dtack_L,
    output logic        ResetOut_L
);

    sdramCmdU cmd;
    addrSelE  addrSel;
    logic     refreshAck;
    logic     refreshDue;
    logic     writeDrive;
    logic     captureRead;

    dramSequencer i_dramSequencer (
        .Clock        (Clock),
        .Reset_L      (Reset_L),
        .DramSelect_L (DramSelect_L),
        .AS_L         (AS_L),
        .WE_L         (WE_L),
        .UDS_L        (UDS_L),
        .LDS_L        (LDS_L),
        .RefreshDue   (refreshDue),
        .Cmd          (cmd),
        .AddrSel      (addrSel),
        .RefreshAck   (refreshAck),
        .WriteDrive   (writeDrive),
        .CaptureRead  (captureRead),
        .Dtack_L      (Dtack_L),
        .ResetOut_L   (ResetOut_L)
    );

    refreshScheduler i_refreshScheduler (
        .Clock      (Clock),
        .Reset_L    (Reset_L),
        .RefreshAck (refreshAck),
        .RefreshDue (refreshDue)
    );

    sdramCommandDriver i_sdramCommandDriver (
        .Clock       (Clock),
        .Reset_L     (Reset_L),
        .Cmd         (cmd),
        .AddrSel     (addrSel),
        .Address     (Address),
        .SDram_CKE_H (SDram_CKE_H),
        .SDram_CS_L  (SDram_CS_L),
        .SDram_RAS_L (SDram_RAS_L),
        .SDram_CAS_L (SDram_CAS_L),
        .SDram_WE_L  (SDram_WE_L),
        .SDram_Addr  (SDram_Addr),
        .SDram_BA    (SDram_BA)
    );

    dramDataPath i_dramDataPath (
        .Clock       (Clock),
        .Reset_L     (Reset_L),
        .WriteDrive  (writeDrive),
        .CaptureRead (captureRead),
        .DataIn      (DataIn),
        .DqIn        (DqIn),
        .DqOut       (DqOut),
        .DqOutEnable (DqOutEnable),
        .DataOut     (DataOut)
    );

endmodule

// ==== dv/sdramModel.sv ====
// Behavioural SDRAM: bank tracking, CL2 read data, word storage and refresh counting
`timescale 1ns/1ps

`include "sdram_config.svh"

module sdramModel (
    input  logic                  Clock,
    input  logic                  SDram_CKE_H,
    input  logic                  SDram_CS_L,
    input  logic                  SDram_RAS_L,
    input  logic                  SDram_CAS_L,
    input  logic                  SDram_WE_L,
    input  logic [`ROW_BITS-1:0]  SDram_Addr,
    input  logic [`BANK_BITS-1:0] SDram_BA,
    input  logic [`DATA_BITS-1:0] DqOut,          // controller drives these
    input  logic                  DqOutEnable,
    output logic [`DATA_BITS-1:0] DqIn,           // read data back to the controller
    output int                    RefreshCount,
    output int                    ModeCount,
    output logic [`ROW_BITS-1:0]  ModeWord,
    output logic                  ProtocolError
);

    localparam int KEY_BITS = `BANK_BITS + `ROW_BITS + `COL_BITS;

    logic [`DATA_BITS-1:0] mem [logic [KEY_BITS-1:0]];   // unwritten words read as zero
    logic [`ROW_BITS-1:0]  openRow [1 << `BANK_BITS];
    logic                  bankOpen [1 << `BANK_BITS];
    logic [KEY_BITS-1:0]   key;
    logic [`DATA_BITS-1:0] readWord;
    logic                  driveRead;
    logic                  autoPrecharge;

    task automatic flagError(input string reason);
        $display("sdram model: %s at %0t", reason, $time);
        ProtocolError = 1'b1;
    endtask

    initial begin
        DqIn          = '0;
        RefreshCount  = 0;
        ModeCount     = 0;
        ModeWord      = '0;
        ProtocolError = 1'b0;
        foreach (bankOpen[b]) bankOpen[b] = 1'b0;
    end

    //////////////////////////////////////////////////////////////////////
    // command decode on the rising edge
    //////////////////////////////////////////////////////////////////////
    always @(posedge Clock) begin
        driveRead     = 1'b0;
        key           = {SDram_BA, openRow[SDram_BA], SDram_Addr[`COL_BITS-1:0]};
        autoPrecharge = (SDram_Addr & `A10_PRECHARGE) != '0;
        if (SDram_CKE_H && !SDram_CS_L) begin           // CKE low means power-up, ignore
            case ({SDram_RAS_L, SDram_CAS_L, SDram_WE_L})
                3'b011: begin                           // activate
                    if (bankOpen[SDram_BA]) begin
                        flagError($sformatf("activate to bank %0d which is already open",
                                            SDram_BA));
                    end
                    bankOpen[SDram_BA] = 1'b1;
                    openRow[SDram_BA]  = SDram_Addr;
                end
                3'b101: begin                           // read
                    if (!bankOpen[SDram_BA]) begin
                        flagError($sformatf("read from bank %0d with no open row", SDram_BA));
                    end
                    readWord  = mem.exists(key) ? mem[key] : '0;
                    driveRead = 1'b1;
                    if (autoPrecharge) bankOpen[SDram_BA] = 1'b0;
                end
                3'b100: begin                           // write
                    if (!bankOpen[SDram_BA]) begin
                        flagError($sformatf("write to bank %0d with no open row", SDram_BA));
                    end
                    if (!DqOutEnable) flagError("write command without data on the bus");
                    mem[key] = DqOut;
                    if (autoPrecharge) bankOpen[SDram_BA] = 1'b0;
                end
                3'b010: begin                           // precharge, one bank or all
                    if (autoPrecharge) begin
                        foreach (bankOpen[b]) bankOpen[b] = 1'b0;
                    end else begin
                        bankOpen[SDram_BA] = 1'b0;
                    end
                end
                3'b001: begin                           // auto-refresh needs all banks idle
                    foreach (bankOpen[b]) begin
                        if (bankOpen[b]) flagError("auto-refresh with a bank still open");
                    end
                    RefreshCount = RefreshCount + 1;
                end
                3'b000: begin                           // load mode register
                    ModeCount = ModeCount + 1;
                    ModeWord  = SDram_Addr;
                end
                default: ;                              // nop
            endcase
        end
        if (driveRead) begin
            #1;                                         // valid well before the capture edge
            DqIn = readWord;
        end
    end

endmodule

// ==== dv/tbM68kDramController.sv ====
// Testbench for the 68000 SDRAM controller: table-driven bus cycles against a behavioural SDRAM
`timescale 1ns/1ps

`include "sdram_config.svh"

module tbM68kDramController;

    localparam logic [1:0] KIND_WRITE  = 2'd0;
    localparam logic [1:0] KIND_READ   = 2'd1;
    localparam logic [1:0] KIND_IDLE   = 2'd2;
    localparam int         INIT_CYCLES = 5 + `POWER_UP_CYCLES + 2 + 1 + `MRS_GAP_CYCLES
                                         + `INIT_REFRESHES * (1 + `REFRESH_GAP_CYCLES);

    typedef struct packed {
        logic [1:0]  kind;
        logic [31:0] addr;
        logic [15:0] data;           // write data, read expectation or idle length
    } entryS;

    logic        Clock;
    logic        Reset_L;
    logic [31:0] Address;
    logic [15:0] DataIn;
    logic        UDS_L;
    logic        LDS_L;
    logic        DramSelect_L;
    logic        WE_L;
    logic        AS_L;
    logic [15:0] DqIn;
    logic [15:0] DataOut;
    logic        SDram_CKE_H;
    logic        SDram_CS_L;
    logic        SDram_RAS_L;
    logic        SDram_CAS_L;
    logic        SDram_WE_L;
    logic [12:0] SDram_Addr;
    logic [1:0]  SDram_BA;
    logic [15:0] DqOut;
    logic        DqOutEnable;
    logic        Dtack_L;
    logic        ResetOut_L;
    int          refreshCount;
    int          modeCount;
    logic [12:0] modeWord;
    logic        protocolError;
    entryS       stimTable [$];
    logic [15:0] lfsrState;
    int          cycleCount = 0;
    int          cycleLimit;
    int          resetOutCycle;

    m68kDramController i_m68kDramController (.*);

    sdramModel i_sdramModel (
        .Clock        (Clock),
        .SDram_CKE_H  (SDram_CKE_H),
        .SDram_CS_L   (SDram_CS_L),
        .SDram_RAS_L  (SDram_RAS_L),
        .SDram_CAS_L  (SDram_CAS_L),
        .SDram_WE_L   (SDram_WE_L),
        .SDram_Addr   (SDram_Addr),
        .SDram_BA     (SDram_BA),
        .DqOut        (DqOut),
        .DqOutEnable  (DqOutEnable),
        .DqIn         (DqIn),
        .RefreshCount (refreshCount),
        .ModeCount    (modeCount),
        .ModeWord     (modeWord),
        .ProtocolError(protocolError)
    );

    initial begin
        Clock = 1'b0;
        forever #50 Clock = ~Clock;  // 100 ns period
    end

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////
    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            abortRun($sformatf("error: %s expected 0x%0h actual 0x%0h", name, expected, actual));
        end
    endtask

    // fibonacci LFSR x^16+x^14+x^13+x^11 stepped once per bit taken
    function automatic int randomBits(input int count);
        int   value;
        logic fb;
        value = 0;
        for (int i = 0; i < count; i++) begin
            fb        = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
            lfsrState = {lfsrState[14:0], fb};
            value     = (value << 1) | int'(fb);
        end
        return value;
    endfunction

    // byte address built from the bank, row and column fields
    function automatic logic [31:0] makeAddr(input logic [1:0] bank, input logic [12:0] rowAddr,
                                             input logic [9:0] col);
        logic [31:0] a;
        a                        = '0;
        a[`BANK_MSB:`BANK_LSB]   = bank;
        a[`ROW_MSB:`ROW_LSB]     = rowAddr;
        a[`COL_MSB:`COL_LSB]     = col;
        return a;
    endfunction

    task automatic addEntry(input logic [1:0] kind, input logic [31:0] addr,
                            input logic [15:0] data);
        entryS e;
        e.kind = kind;
        e.addr = addr;
        e.data = data;
        stimTable.push_back(e);
    endtask

    task automatic buildTable;
        addEntry(KIND_WRITE, makeAddr(0, 13'h0001, 10'h002), 16'hA5C3);
        addEntry(KIND_WRITE, makeAddr(1, 13'h1ABC, 10'h3FF), 16'h1234);
        addEntry(KIND_READ,  makeAddr(0, 13'h0001, 10'h002), 16'hA5C3);
        addEntry(KIND_READ,  makeAddr(1, 13'h1ABC, 10'h3FF), 16'h1234);
        addEntry(KIND_READ,  makeAddr(2, 13'h1ABC, 10'h3FF), 16'h0000);   // other bank only
        addEntry(KIND_READ,  makeAddr(3, 13'h0F0F, 10'h155), 16'h0000);   // never written
        addEntry(KIND_WRITE, makeAddr(1, 13'h1ABC, 10'h3FF), 16'hBEEF);
        addEntry(KIND_WRITE, makeAddr(3, 13'h1FFF, 10'h000), 16'h0F0F);
        addEntry(KIND_IDLE,  32'h0, 16'd450);                              // refresh window
        addEntry(KIND_READ,  makeAddr(1, 13'h1ABC, 10'h3FF), 16'hBEEF);
        addEntry(KIND_READ,  makeAddr(1, 13'h1ABC, 10'h3FF) | 32'hFC00_0001, 16'hBEEF);
        addEntry(KIND_READ,  makeAddr(3, 13'h1FFF, 10'h000), 16'h0F0F);
        addEntry(KIND_READ,  makeAddr(0, 13'h0001, 10'h003), 16'h0000);   // next column
        addEntry(KIND_WRITE, makeAddr(2, 13'h0000, 10'h155), 16'hC001);
        addEntry(KIND_READ,  makeAddr(2, 13'h0000, 10'h155), 16'hC001);
    endtask

    task automatic stepCycle;
        @(posedge Clock);
        #1;                          // drive and sample just after the edge
    endtask

    //////////////////////////////////////////////////////////////////////
    // 68000 bus cycles
    //////////////////////////////////////////////////////////////////////
    task automatic holdAndRelease(input int holdCycles);
        repeat (holdCycles) begin
            stepCycle();
            checkValue("dtack while strobes held", 32'd0, Dtack_L);
        end
        UDS_L = 1'b1;                // upper lane released first
        stepCycle();
        checkValue("dtack with lower strobe still held", 32'd0, Dtack_L);
        LDS_L        = 1'b1;
        AS_L         = 1'b1;
        DramSelect_L = 1'b1;
        WE_L         = 1'b1;
        stepCycle();
        checkValue("dtack after both strobes released", 32'd1, Dtack_L);
    endtask

    task automatic busWrite(input logic [31:0] addr, input logic [15:0] data, input int hold);
        checkValue("dtack idle before write", 32'd1, Dtack_L);
        Address      = addr;
        DataIn       = data;
        WE_L         = 1'b0;
        DramSelect_L = 1'b0;
        AS_L         = 1'b0;
        stepCycle();
        UDS_L        = 1'b0;         // data strobes a cycle after AS on a write
        LDS_L        = 1'b0;
        while (Dtack_L) stepCycle();     // activate, write and recover
        holdAndRelease(hold);
    endtask

    task automatic busRead(input string name, input logic [31:0] addr,
                           input logic [15:0] expected, input int hold);
        checkValue("dtack idle before read", 32'd1, Dtack_L);
        Address      = addr;
        WE_L         = 1'b1;
        DramSelect_L = 1'b0;
        AS_L         = 1'b0;
        UDS_L        = 1'b0;
        LDS_L        = 1'b0;
        while (Dtack_L) stepCycle();
        checkValue(name, 32'(expected), 32'(DataOut));   // valid on the dtack edge
        holdAndRelease(hold);
    endtask

    // watchdog for model errors and the cycle limit
    always @(posedge Clock) begin
        cycleCount <= cycleCount + 1;
        if (protocolError) begin
            abortRun("the SDRAM model saw an illegal command sequence");
        end else if (cycleCount > cycleLimit) begin
            abortRun($sformatf("timeout: run did not finish within %0d cycles", cycleLimit));
        end
    end

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        int    gap;
        int    hold;
        int    periodic;
        int    required;
        entryS e;
        buildTable();
        cycleLimit   = INIT_CYCLES + stimTable.size() * (64 + 40) + 800;
        lfsrState    = 16'd53832;
        Reset_L      = 1'b0;
        Address      = '0;
        DataIn       = '0;
        UDS_L        = 1'b1;
        LDS_L        = 1'b1;
        DramSelect_L = 1'b1;
        WE_L         = 1'b1;
        AS_L         = 1'b1;
        repeat (5) @(posedge Clock);
        #1;
        Reset_L = 1'b1;
        checkValue("dtack after reset", 32'd1, Dtack_L);
        checkValue("reset out after reset", 32'd0, ResetOut_L);
        checkValue("dq enable after reset", 32'd0, DqOutEnable);
        checkValue("data out after reset", 32'd0, DataOut);
        checkValue("command pins after reset", 32'd0,
                   {SDram_CKE_H, SDram_CS_L, SDram_RAS_L, SDram_CAS_L, SDram_WE_L});
        while (!ResetOut_L) stepCycle();
        resetOutCycle = cycleCount;
        checkValue("init refresh count", `INIT_REFRESHES, refreshCount);
        checkValue("mode load count", 32'd1, modeCount);
        checkValue("mode word", `MODE_WORD, modeWord);
        checkValue("dtack at end of init", 32'd1, Dtack_L);

        foreach (stimTable[i]) begin
            e    = stimTable[i];
            gap  = randomBits(6);
            hold = randomBits(5) % 21;
            repeat (gap) stepCycle();
            case (e.kind)
                KIND_WRITE: busWrite(e.addr, e.data, hold);
                KIND_READ:  busRead($sformatf("read entry %0d", i), e.addr, e.data, hold);
                default:    repeat (int'(e.data)) stepCycle();
            endcase
        end

        checkValue("sdram model protocol error", 32'd0, 32'(protocolError));
        periodic = refreshCount - `INIT_REFRESHES;
        required = (cycleCount - resetOutCycle) / (`REFRESH_INTERVAL + 40);
        checkValue("refresh in long idle", 32'd1, 32'(periodic >= 1));
        checkValue("refreshes against elapsed cycles", 32'd1, 32'(periodic >= required));
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+include
source/sdramPkg.sv
source/dramSequencer.sv
source/refreshScheduler.sv
source/sdramCommandDriver.sv
source/dramDataPath.sv
source/m68kDramController.sv
dv/sdramModel.sv
dv/tbM68kDramController.sv

// ==== run.sh ====
#!/bin/sh
# build the controller testbench with Verilator, run it and look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f src.f --top-module tbM68kDramController \
    --Mdir obj_dir -o simTb > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/simTb > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -q "ALL CHECKS PASSED" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1
